//--- include/tmds_macros.svh
// Raster geometry, sync positions and symbol width for the TMDS test pattern
`ifndef TMDS_MACROS_SVH
`define TMDS_MACROS_SVH

// Raster size, kept tiny for simulation
`define TMDS_H_ACTIVE 8
`define TMDS_H_TOTAL 12
`define TMDS_V_ACTIVE 4
`define TMDS_V_TOTAL 6

// Sync positions inside the blanking interval
`define TMDS_HSYNC_START 9
`define TMDS_HSYNC_END 11
`define TMDS_VSYNC_LINE 5

// Symbol width and the fixed clock-lane pattern
`define TMDS_SYM_BITS 10
`define TMDS_CLK_SYMBOL 10'b11111_00000

`endif

//--- hw/tmds_pkg.sv
// Shared types for the TMDS test pattern: pixel word, lane inputs, symbols
`include "tmds_macros.svh"

package tmds_pkg;

	// Three data lanes, the clock lane is extra
	localparam int NUM_LANES = 3;

	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} rgb_t;

	// Sync flags sit in the low bits, rest unused
	typedef struct packed {
		logic [21:0] reserved;
		logic vsync;
		logic hsync;
	} sync_t;

	// Same 24 bits, read as colour or as sync by de
	typedef union packed {
		rgb_t rgb;
		sync_t sync;
	} pixel_word_u;

	typedef struct packed {
		logic de;
		pixel_word_u word;
	} pixel_t;

	// What one encoder needs per pixel
	typedef struct packed {
		logic de;
		logic [1:0] ctrl;
		logic [7:0] data;
	} lane_in_t;

	typedef logic [`TMDS_SYM_BITS-1:0] symbol_t;

	typedef enum logic [1:0] {
		PAT_RAMP,
		PAT_CHECKER,
		PAT_SOLID
	} pattern_e;

endpackage

//--- hw/tmds_pattern_gen.sv
// Raster timing generator with pixel strobe, pattern selection and lane split
`include "tmds_macros.svh"

module tmds_pattern_gen (
	input logic clk,
	input logic rst,
	input logic enable,
	input tmds_pkg::pattern_e mode,
	input tmds_pkg::rgb_t solid_color,
	output tmds_pkg::lane_in_t [tmds_pkg::NUM_LANES-1:0] lanes,
	output logic pix_stb
);

	localparam int XW = $clog2(`TMDS_H_TOTAL);
	localparam int YW = $clog2(`TMDS_V_TOTAL);
	localparam int PHASE_LAST = `TMDS_SYM_BITS - 1;

	logic [3:0] phase;
	logic [XW-1:0] x;
	logic [YW-1:0] y;
	tmds_pkg::pixel_t pix;

	// One pixel per symbol time
	assign pix_stb = enable && (phase == 4'(PHASE_LAST));

	always_ff @(posedge clk) begin
		if (rst || !enable) begin
			phase <= '0;
			x <= '0;
			y <= '0;
		end else begin
			phase <= pix_stb ? 4'd0 : phase + 4'd1;
			if (pix_stb) begin
				if (x == XW'(`TMDS_H_TOTAL - 1)) begin
					x <= '0;
					y <= (y == YW'(`TMDS_V_TOTAL - 1)) ? '0 : y + YW'(1);
				end else begin
					x <= x + XW'(1);
				end
			end
		end
	end

	// Pixel at the current raster position
	always_comb begin
		pix = '0;
		pix.de = (x < XW'(`TMDS_H_ACTIVE)) && (y < YW'(`TMDS_V_ACTIVE));
		if (pix.de) begin
			case (mode)
				tmds_pkg::PAT_RAMP: begin
					pix.word.rgb.red = {x[2:0], 5'b0};
					pix.word.rgb.green = {y[1:0], 6'b0};
					pix.word.rgb.blue = {x[2:0], 5'b0} ^ {y[1:0], 6'b0};
				end
				tmds_pkg::PAT_CHECKER: pix.word.rgb = {24{x[0] ^ y[0]}};
				tmds_pkg::PAT_SOLID: pix.word.rgb = solid_color;
				default: pix.word.rgb = '0;
			endcase
		end else begin
			pix.word.sync.hsync = (x >= XW'(`TMDS_HSYNC_START)) &&
				(x < XW'(`TMDS_HSYNC_END));
			pix.word.sync.vsync = (y == YW'(`TMDS_VSYNC_LINE));
		end
	end

	// Lane 0 blue, 1 green, 2 red; only lane 0 carries sync
	always_comb begin
		lanes = '0;
		if (pix.de) begin
			lanes[0].de = 1'b1;
			lanes[0].data = pix.word.rgb.blue;
			lanes[1].de = 1'b1;
			lanes[1].data = pix.word.rgb.green;
			lanes[2].de = 1'b1;
			lanes[2].data = pix.word.rgb.red;
		end else begin
			lanes[0].ctrl = {pix.word.sync.vsync, pix.word.sync.hsync};
		end
	end

	a_x_in_range: assert property (@(posedge clk) disable iff (rst)
		x < XW'(`TMDS_H_TOTAL))
		else $error("pattern gen column counter out of range");

endmodule

//--- hw/tmds_encoder.sv
// DVI TMDS encoder for one lane, with running disparity and control symbols

module tmds_encoder (
	input logic clk,
	input logic rst,
	input tmds_pkg::lane_in_t lane,
	input logic pix_stb,
	output tmds_pkg::symbol_t sym,
	output logic sym_stb
);

	logic [3:0] n1_d;
	logic [3:0] n1_q;
	logic [3:0] n0_q;
	logic use_xnor;
	logic [8:0] q_m;
	logic signed [5:0] bal;
	logic signed [5:0] disp;
	logic signed [5:0] disp_next;
	tmds_pkg::symbol_t q_out;
	tmds_pkg::symbol_t ctrl_sym;

	// Stage one, minimise transitions
	always_comb begin
		n1_d = '0;
		for (int i = 0; i < 8; i++)
			n1_d = n1_d + 4'(lane.data[i]);
		use_xnor = (n1_d > 4'd4) || (n1_d == 4'd4 && !lane.data[0]);
		q_m[0] = lane.data[0];
		for (int i = 1; i < 8; i++)
			q_m[i] = use_xnor ? ~(q_m[i-1] ^ lane.data[i]) : (q_m[i-1] ^ lane.data[i]);
		q_m[8] = ~use_xnor;
		n1_q = '0;
		for (int i = 0; i < 8; i++)
			n1_q = n1_q + 4'(q_m[i]);
		n0_q = 4'd8 - n1_q;
		// Ones minus zeros of the stage-one byte
		bal = $signed({2'b00, n1_q}) - $signed({2'b00, n0_q});
	end

	// Stage two, DC balance against the running disparity
	always_comb begin
		if (disp == 6'sd0 || n1_q == n0_q) begin
			q_out = {~q_m[8], q_m[8], q_m[8] ? q_m[7:0] : ~q_m[7:0]};
			disp_next = q_m[8] ? disp + bal : disp - bal;
		end else if ((disp > 6'sd0 && n1_q > n0_q) || (disp < 6'sd0 && n0_q > n1_q)) begin
			q_out = {1'b1, q_m[8], ~q_m[7:0]};
			disp_next = disp + $signed({4'b0000, q_m[8], 1'b0}) - bal;
		end else begin
			q_out = {1'b0, q_m[8], q_m[7:0]};
			disp_next = disp - $signed({4'b0000, ~q_m[8], 1'b0}) + bal;
		end
	end

	always_comb begin
		case (lane.ctrl)
			2'b00: ctrl_sym = 10'b1101010100;
			2'b01: ctrl_sym = 10'b0010101011;
			2'b10: ctrl_sym = 10'b0101010100;
			default: ctrl_sym = 10'b1010101011;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			sym_stb <= 1'b0;
			disp <= '0;
		end else begin
			sym_stb <= pix_stb;
			// Blanking restarts the balance
			if (pix_stb)
				disp <= lane.de ? disp_next : '0;
		end
	end

	always_ff @(posedge clk) begin
		if (pix_stb)
			sym <= lane.de ? q_out : ctrl_sym;
	end

	a_disp_bounded: assert property (@(posedge clk) disable iff (rst)
		disp >= -6'sd10 && disp <= 6'sd10)
		else $error("TMDS running disparity out of bounds");

endmodule

//--- hw/tmds_serializer.sv
// Four-lane shift-out of TMDS symbols with complementary output pairs
`include "tmds_macros.svh"

module tmds_serializer (
	input logic clk,
	input logic rst,
	input logic enable,
	input tmds_pkg::symbol_t [tmds_pkg::NUM_LANES-1:0] syms,
	input logic sym_stb,
	output logic [3:0] tmds_p,
	output logic [3:0] tmds_n
);

	// Data lanes then the clock lane
	tmds_pkg::symbol_t [3:0] shift;

	always_ff @(posedge clk) begin
		if (rst || !enable) begin
			shift <= '0;
		end else if (sym_stb) begin
			for (int i = 0; i < tmds_pkg::NUM_LANES; i++)
				shift[i] <= syms[i];
			shift[3] <= `TMDS_CLK_SYMBOL;
		end else begin
			for (int i = 0; i < 4; i++)
				shift[i] <= shift[i] >> 1;
		end
	end

	// LSB first on the pins
	always_comb begin
		for (int i = 0; i < 4; i++)
			tmds_p[i] = shift[i][0];
		tmds_n = ~tmds_p;
	end

	// Each load follows the previous one by exactly one symbol time
	a_load_spacing: assert property (@(posedge clk) disable iff (rst || !enable)
		sym_stb |=> !sym_stb [*(`TMDS_SYM_BITS - 1)] ##1 sym_stb)
		else $error("serializer load spacing is not one symbol time");

endmodule

//--- hw/tmds_test.sv
// TMDS test pattern top: raster generator, lane encoders and serializer

module tmds_test (
	input logic clk,
	input logic rst,
	input logic enable,
	input tmds_pkg::pattern_e mode,
	input tmds_pkg::rgb_t solid_color,
	output logic [3:0] tmds_p,
	output logic [3:0] tmds_n
);

	tmds_pkg::lane_in_t [tmds_pkg::NUM_LANES-1:0] lanes;
	tmds_pkg::symbol_t [tmds_pkg::NUM_LANES-1:0] syms;
	logic [tmds_pkg::NUM_LANES-1:0] sym_stb;
	logic pix_stb;

	tmds_pattern_gen u_pattern_gen (
		.clk(clk),
		.rst(rst),
		.enable(enable),
		.mode(mode),
		.solid_color(solid_color),
		.lanes(lanes),
		.pix_stb(pix_stb)
	);

	// Lane 0 blue, 1 green, 2 red
	for (genvar g = 0; g < tmds_pkg::NUM_LANES; g++) begin : g_lane
		tmds_encoder u_encoder (
			.clk(clk),
			.rst(rst),
			.lane(lanes[g]),
			.pix_stb(pix_stb),
			.sym(syms[g]),
			.sym_stb(sym_stb[g])
		);
	end

	// Lanes run in lockstep, lane 0 strobe stands for all
	tmds_serializer u_serializer (
		.clk(clk),
		.rst(rst),
		.enable(enable),
		.syms(syms),
		.sym_stb(sym_stb[0]),
		.tmds_p(tmds_p),
		.tmds_n(tmds_n)
	);

endmodule

//--- verification/tmds_tb_model.svh
// Reference models for the TMDS testbench: DVI encoder, control symbols,
// raster pattern and sync rules, Galois LFSR
`ifndef TMDS_TB_MODEL_SVH
`define TMDS_TB_MODEL_SVH

	// DVI video encoding, disparity carried through disp
	function automatic logic [9:0] encode_video(input logic [7:0] d, inout int disp);
		int ones_d;
		int ones_m;
		int zeros_m;
		logic xnor_mode;
		logic [8:0] q;
		logic [9:0] s;
		ones_d = 0;
		for (int i = 0; i < 8; i++)
			if (d[i])
				ones_d++;
		xnor_mode = (ones_d > 4) || (ones_d == 4 && !d[0]);
		q[0] = d[0];
		for (int i = 1; i < 8; i++)
			q[i] = xnor_mode ? (q[i-1] ~^ d[i]) : (q[i-1] ^ d[i]);
		q[8] = !xnor_mode;
		ones_m = 0;
		for (int i = 0; i < 8; i++)
			if (q[i])
				ones_m++;
		zeros_m = 8 - ones_m;
		if (disp == 0 || ones_m == zeros_m) begin
			s = {~q[8], q[8], q[8] ? q[7:0] : ~q[7:0]};
			disp = q[8] ? disp + ones_m - zeros_m : disp + zeros_m - ones_m;
		end else if ((disp > 0 && ones_m > zeros_m) || (disp < 0 && zeros_m > ones_m)) begin
			s = {1'b1, q[8], ~q[7:0]};
			disp = disp + (q[8] ? 2 : 0) + zeros_m - ones_m;
		end else begin
			s = {1'b0, q[8], q[7:0]};
			disp = disp - (q[8] ? 0 : 2) + ones_m - zeros_m;
		end
		return s;
	endfunction

	// Control symbols indexed by {C1, C0}
	function automatic logic [9:0] control_symbol(input logic [1:0] c);
		case (c)
			2'b00: return 10'b1101010100;
			2'b01: return 10'b0010101011;
			2'b10: return 10'b0101010100;
			default: return 10'b1010101011;
		endcase
	endfunction

	function automatic int ones_minus_zeros(input logic [9:0] s);
		int n;
		n = 0;
		for (int i = 0; i < 10; i++)
			if (s[i])
				n++;
		return 2 * n - 10;
	endfunction

	function automatic logic in_active(input int x, input int y);
		return (x < `TMDS_H_ACTIVE) && (y < `TMDS_V_ACTIVE);
	endfunction

	// {vsync, hsync} at a blanking position
	function automatic logic [1:0] sync_ctrl(input int x, input int y);
		return {y == `TMDS_VSYNC_LINE, x >= `TMDS_HSYNC_START && x < `TMDS_HSYNC_END};
	endfunction

	// Colour as {red, green, blue}
	function automatic logic [23:0] pattern_rgb(input tmds_pkg::pattern_e m,
			input logic [23:0] solid, input int x, input int y);
		logic [7:0] r;
		logic [7:0] g;
		case (m)
			tmds_pkg::PAT_RAMP: begin
				r = 8'(x * 32);
				g = 8'(y * 64);
				return {r, g, r ^ g};
			end
			tmds_pkg::PAT_CHECKER: return ((x ^ y) & 1) != 0 ? 24'hffffff : 24'h000000;
			default: return solid;
		endcase
	endfunction

	// Galois form, x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

`endif

//--- verification/tmds_test_tb.sv
// Testbench for the TMDS test pattern top with its stimulus table, pin deserializer
// and checks against the reference model
`include "tmds_macros.svh"

module tmds_test_tb;

	localparam int FRAME_PIXELS = `TMDS_H_TOTAL * `TMDS_V_TOTAL;
	localparam int CTRL_PER_FRAME = FRAME_PIXELS - `TMDS_H_ACTIVE * `TMDS_V_ACTIVE;
	localparam int NUM_TESTS = 10;
	// Cycles from enable rising to bit 0 of the first symbol
	localparam int FIRST_BIT = 11;

	typedef struct packed {
		logic en;
		tmds_pkg::pattern_e mode;
		logic rand_color;
		tmds_pkg::rgb_t color;
		logic [7:0] frames;
		logic [7:0] extra;
		logic [7:0] ctrl_count;
	} test_row_t;

	logic clk;
	logic rst;
	logic enable;
	tmds_pkg::pattern_e mode;
	tmds_pkg::rgb_t solid_color;
	logic [3:0] tmds_p;
	logic [3:0] tmds_n;

	test_row_t rows [NUM_TESTS];
	logic [31:0] lfsr_state;
	int model_disp [3];
	int checks;
	int errors;

	`include "tmds_tb_model.svh"

	tmds_test u_tmds_test (
		.clk(clk),
		.rst(rst),
		.enable(enable),
		.mode(mode),
		.solid_color(solid_color),
		.tmds_p(tmds_p),
		.tmds_n(tmds_n)
	);

	always #2 clk = ~clk;

	task automatic check_equal(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		assert (got == exp) else begin
			$display("[FAIL] %0t %s: got %0h, expected %0h", $time, what, got, exp);
			errors++;
		end
	endtask

	// Serializer cleared with every pair at rest
	task automatic watch_idle(input int cycles);
		for (int i = 0; i < cycles; i++) begin
			@(negedge clk);
			check_equal("idle tmds_p", {28'h0, tmds_p}, 32'h0);
			check_equal("idle tmds_n", {28'h0, tmds_n}, 32'hf);
		end
	endtask

	task automatic draw_color(output tmds_pkg::rgb_t c);
		logic [23:0] bits;
		for (int i = 0; i < 24; i++) begin
			bits[i] = lfsr_state[0];
			lfsr_state = lfsr_next(lfsr_state);
		end
		c = bits;
	endtask

	// Expected data-lane symbols of raster pixel k and the next model disparity
	task automatic model_pixel(input int k, input test_row_t row, output logic [2:0][9:0] exp);
		int x;
		int y;
		int d;
		logic [23:0] rgb;
		x = k % `TMDS_H_TOTAL;
		y = (k / `TMDS_H_TOTAL) % `TMDS_V_TOTAL;
		rgb = pattern_rgb(row.mode, row.color, x, y);
		for (int i = 0; i < 3; i++) begin
			if (in_active(x, y)) begin
				d = model_disp[i];
				exp[i] = encode_video(rgb[8*i +: 8], d);
				model_disp[i] = d;
			end else begin
				exp[i] = control_symbol(i == 0 ? sync_ctrl(x, y) : 2'b00);
				model_disp[i] = 0;
			end
		end
	endtask

	// Enable from the frame origin, deserialize and check, then drop enable
	task automatic run_row(input test_row_t row);
		int target;
		int n;
		int k;
		int x;
		int y;
		int ctrl_seen;
		int line_start [3];
		int line_sum [3];
		logic [3:0][9:0] shreg;
		logic [3:0][9:0] shreg_n;
		logic [2:0][9:0] exp;
		target = int'(row.frames) * FRAME_PIXELS + int'(row.extra);
		n = 0;
		k = 0;
		ctrl_seen = 0;
		shreg = '0;
		shreg_n = '0;
		@(negedge clk);
		mode = row.mode;
		solid_color = row.color;
		enable = 1'b1;
		while (k < target) begin
			@(negedge clk);
			n++;
			if (n < FIRST_BIT) begin
				check_equal("tmds_p before first load", {28'h0, tmds_p}, 32'h0);
				check_equal("tmds_n before first load", {28'h0, tmds_n}, 32'hf);
			end else begin
				for (int l = 0; l < 4; l++) begin
					shreg[l][(n - FIRST_BIT) % 10] = tmds_p[l];
					shreg_n[l][(n - FIRST_BIT) % 10] = tmds_n[l];
				end
				if ((n - FIRST_BIT) % 10 == 9) begin
					x = k % `TMDS_H_TOTAL;
					y = (k / `TMDS_H_TOTAL) % `TMDS_V_TOTAL;
					if (x == 0) begin
						for (int l = 0; l < 3; l++) begin
							line_start[l] = model_disp[l];
							line_sum[l] = 0;
						end
					end
					model_pixel(k, row, exp);
					check_equal("clock lane", 32'(shreg[3]), 32'(`TMDS_CLK_SYMBOL));
					check_equal("clock lane tmds_n", {22'h0, shreg_n[3]},
						{22'h0, ~`TMDS_CLK_SYMBOL});
					for (int l = 0; l < 3; l++) begin
						check_equal($sformatf("lane %0d pixel %0d", l, k),
							32'(shreg[l]), 32'(exp[l]));
						check_equal($sformatf("lane %0d pixel %0d tmds_n", l, k),
							{22'h0, shreg_n[l]}, {22'h0, ~exp[l]});
						line_sum[l] += ones_minus_zeros(shreg[l]);
					end
					if (in_active(x, y) && x == `TMDS_H_ACTIVE - 1) begin
						for (int l = 0; l < 3; l++)
							check_equal($sformatf("lane %0d line %0d disparity", l, y),
								line_start[l] + line_sum[l], model_disp[l]);
					end
					for (int c = 0; c < 4; c++)
						if (shreg[0] == control_symbol(2'(c)))
							ctrl_seen++;
					if (k % FRAME_PIXELS == FRAME_PIXELS - 1) begin
						check_equal("control symbols per frame", ctrl_seen,
							32'(row.ctrl_count));
						ctrl_seen = 0;
					end
					k++;
				end
			end
		end
		enable = 1'b0;
		// Pixels already taken by the encoders but not yet on the pins
		for (int j = k; j < n / 10; j++)
			model_pixel(j, row, exp);
		watch_idle(4);
	endtask

	initial begin
		test_row_t row;
		int errs_before;
		int tests_run;
		clk = 1'b0;
		rst = 1'b1;
		enable = 1'b0;
		mode = tmds_pkg::PAT_RAMP;
		solid_color = '0;
		lfsr_state = 32'hfba9;
		model_disp = '{0, 0, 0};
		checks = 0;
		errors = 0;
		tests_run = 0;
		// en, mode, random colour, colour, frames, extra pixels, control symbols
		rows[0] = '{1'b0, tmds_pkg::PAT_RAMP, 1'b0, 24'h0, 8'd1, 8'd0, 8'(CTRL_PER_FRAME)};
		rows[1] = '{1'b1, tmds_pkg::PAT_RAMP, 1'b0, 24'h0, 8'd2, 8'd0, 8'(CTRL_PER_FRAME)};
		rows[2] = '{1'b1, tmds_pkg::PAT_CHECKER, 1'b0, 24'h0, 8'd1, 8'd0, 8'(CTRL_PER_FRAME)};
		rows[3] = '{1'b1, tmds_pkg::PAT_RAMP, 1'b0, 24'h0, 8'd0, 8'd29, 8'(CTRL_PER_FRAME)};
		rows[4] = '{1'b1, tmds_pkg::PAT_RAMP, 1'b0, 24'h0, 8'd1, 8'd0, 8'(CTRL_PER_FRAME)};
		rows[5] = '{1'b1, tmds_pkg::PAT_SOLID, 1'b1, 24'h0, 8'd1, 8'd0, 8'(CTRL_PER_FRAME)};
		rows[6] = '{1'b1, tmds_pkg::PAT_SOLID, 1'b1, 24'h0, 8'd1, 8'd0, 8'(CTRL_PER_FRAME)};
		rows[7] = '{1'b1, tmds_pkg::PAT_SOLID, 1'b0, 24'h1e5a87, 8'd1, 8'd0, 8'(CTRL_PER_FRAME)};
		rows[8] = '{1'b1, tmds_pkg::PAT_CHECKER, 1'b0, 24'h0, 8'd0, 8'd13, 8'(CTRL_PER_FRAME)};
		rows[9] = '{1'b1, tmds_pkg::PAT_SOLID, 1'b1, 24'h0, 8'd1, 8'd0, 8'(CTRL_PER_FRAME)};
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		for (int t = 0; t < NUM_TESTS; t++) begin
			row = rows[t];
			errs_before = errors;
			if (row.rand_color)
				draw_color(row.color);
			if (row.en)
				run_row(row);
			else
				watch_idle(int'(row.frames) * FRAME_PIXELS * 10);
			tests_run++;
			$display("test %0d: mode %0d, colour %06h, %0d errors", t, row.mode, row.color,
				errors - errs_before);
		end
		$display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

//--- verilog.f
+incdir+include
+incdir+verification
hw/tmds_pkg.sv
hw/tmds_pattern_gen.sv
hw/tmds_encoder.sv
hw/tmds_serializer.sv
hw/tmds_test.sv
verification/tmds_test_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the TMDS testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --assert --top-module tmds_test_tb -f verilog.f -o tmds_sim
./obj_dir/tmds_sim | tee sim.log
if grep -q "Verification failed" sim.log; then
	exit 1
fi
exit 0
